// File: common/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// ------------------------------------------------------------------------
// Backend sizing
// ------------------------------------------------------------------------

`define ROB_DEPTH   16      // Reorder buffer entries
`define IQ_DEPTH    4       // Entries per issue queue
`define PHYS_TAGS   8       // Free list size, kept below ROB_DEPTH
`define SEQ_BITS    16      // Front end sequence id width

// ------------------------------------------------------------------------
// Literals
// ------------------------------------------------------------------------

`define TRUE        1'b1
`define FALSE       1'b0

`endif

// File: common/BackendPkg.sv
`include "backend_defines.svh"

package BackendPkg;

    // Execution class picks the issue queue
    typedef enum logic [1:0] {
        ClassAlu,
        ClassLsu,
        ClassMdu
    } InstClass;

    typedef logic [`SEQ_BITS-1:0]          SeqId;
    typedef logic [$clog2(`PHYS_TAGS)-1:0] PhysTag;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] RobIdx;

    // Decode and rename stage payload
    typedef struct packed {
        SeqId     seq;
        InstClass cls;
        logic     mispredict;       // Resolved at commit
    } InstInfo;

    // Dispatch stage payload
    typedef struct packed {
        InstInfo info;
        PhysTag  tag;
    } RenamedInst;

    // One issue queue slot
    typedef struct packed {
        SeqId  seq;
        RobIdx robIdx;              // Completion goes back here
    } IssueEntry;

endpackage

// File: verilog/CtrlUnitBackend.sv
`timescale 1ns/1ns

module CtrlUnitBackend (
    input  logic robPauseReq,
    input  logic flushReq,
    input  logic aluIQReady,
    input  logic lsuIQReady,
    input  logic mduIQReady,
    input  logic renameAllocatable,

    output logic decodePause,
    output logic renameRegPause,
    output logic pauseRename,
    output logic dispatchPause,

    output logic pipeFlush,
    output logic renameRecover,
    output logic aluIQFlush,
    output logic lsuIQFlush,
    output logic mduIQFlush,
    output logic robFlush,
    output logic flush
);

    logic downstreamFull;

    // ------------------------------------------------------------------------
    // Pause
    // ------------------------------------------------------------------------

    assign downstreamFull = robPauseReq || !aluIQReady || !lsuIQReady || !mduIQReady;

    // Front stages also wait for a free tag
    assign decodePause    = downstreamFull || !renameAllocatable;
    assign renameRegPause = downstreamFull || !renameAllocatable;

    // Rename and dispatch only see back-pressure, a missing tag leaves a bubble
    assign pauseRename    = downstreamFull;
    assign dispatchPause  = downstreamFull;

    // ------------------------------------------------------------------------
    // Flush fan-out
    // ------------------------------------------------------------------------

    assign pipeFlush      = flushReq;
    assign renameRecover  = flushReq;
    assign aluIQFlush     = flushReq;
    assign lsuIQFlush     = flushReq;
    assign mduIQFlush     = flushReq;
    assign robFlush       = flushReq;
    assign flush          = flushReq;

endmodule

// File: verilog/PipeReg.sv
`timescale 1ns/1ns
`include "backend_defines.svh"

module PipeReg #(
    parameter type PayloadType = logic
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       pause,
    input  logic       flush,
    input  logic       inValid,
    input  PayloadType inData,
    output logic       outValid,
    output PayloadType outData
);

    // Flush wins over pause
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            outValid <= `FALSE;
        end else if (!pause) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause) begin
            outData <= inData;      // Meaningless while outValid is low
        end
    end

endmodule

// File: rename/RenameUnit.sv
`timescale 1ns/1ns
`include "backend_defines.svh"

module RenameUnit import BackendPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   allocReq,
    input  logic   pauseRename,
    input  logic   freeValid,
    input  PhysTag freeTag,
    input  logic   recover,
    output logic   allocatable,
    output PhysTag allocTag
);

    PhysTag                     freeList [`PHYS_TAGS];
    PhysTag                     headPtr;
    PhysTag                     tailPtr;
    logic [$clog2(`PHYS_TAGS):0] freeCount;
    logic                       allocFire;

    assign allocatable = (freeCount != 0);
    assign allocTag    = freeList[headPtr];
    assign allocFire   = allocReq && !pauseRename && allocatable;

    // ------------------------------------------------------------------------
    // Free list
    // ------------------------------------------------------------------------

    // Recover is safe since the flush also drains the reorder buffer
    always_ff @(posedge clk) begin
        if (reset || recover) begin
            headPtr   <= '0;
            tailPtr   <= '0;
            freeCount <= `PHYS_TAGS;
            for (int i = 0; i < `PHYS_TAGS; i++) begin
                freeList[i] <= PhysTag'(i);
            end
        end else begin
            if (allocFire) begin
                headPtr <= headPtr + 1'b1;
            end
            if (freeValid) begin
                freeList[tailPtr] <= freeTag;   // Committed tag goes to the tail
                tailPtr           <= tailPtr + 1'b1;
            end
            if (allocFire && !freeValid) begin
                freeCount <= freeCount - 1'b1;
            end else if (freeValid && !allocFire) begin
                freeCount <= freeCount + 1'b1;
            end
        end
    end

endmodule

// File: issue/IssueQueue.sv
`timescale 1ns/1ns
`include "backend_defines.svh"

module IssueQueue import BackendPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      writeValid,
    input  IssueEntry writeEntry,
    input  logic      grant,
    output logic      ready,
    output logic      issueValid,
    output IssueEntry issueEntry
);

    IssueEntry                  entryMem [`IQ_DEPTH];
    logic [$clog2(`IQ_DEPTH)-1:0] headPtr;
    logic [$clog2(`IQ_DEPTH)-1:0] tailPtr;
    logic [$clog2(`IQ_DEPTH):0]   count;
    logic                       popFire;

    // One free slot is enough, dispatch stalls before the stage regs spill
    assign ready      = (count != `IQ_DEPTH);
    assign issueValid = (count != 0);
    assign issueEntry = entryMem[headPtr];
    assign popFire    = grant && issueValid;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (writeValid) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (popFire) begin
                headPtr <= headPtr + 1'b1;
            end
            if (writeValid && !popFire) begin
                count <= count + 1'b1;
            end else if (popFire && !writeValid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeValid) begin
            entryMem[tailPtr] <= writeEntry;
        end
    end

endmodule

// File: rob/ReorderBuffer.sv
`timescale 1ns/1ns
`include "backend_defines.svh"

module ReorderBuffer import BackendPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,

    input  logic       allocValid,
    input  RenamedInst allocInst,
    output RobIdx      allocIdx,
    output logic       pauseReq,

    input  logic       aluDoneValid,
    input  RobIdx      aluDoneIdx,
    input  logic       lsuDoneValid,
    input  RobIdx      lsuDoneIdx,
    input  logic       mduDoneValid,
    input  RobIdx      mduDoneIdx,

    output logic       commitValid,
    output SeqId       commitSeq,
    output PhysTag     commitTag,
    output logic       flushReq
);

    SeqId                        seqMem     [`ROB_DEPTH];
    PhysTag                      tagMem     [`ROB_DEPTH];
    logic                        mispredMem [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]       doneBits;
    RobIdx                       headIdx;
    RobIdx                       tailIdx;
    logic [$clog2(`ROB_DEPTH):0] count;

    assign allocIdx    = tailIdx;
    assign pauseReq    = (count == `ROB_DEPTH);

    // ------------------------------------------------------------------------
    // Commit
    // ------------------------------------------------------------------------

    assign commitValid = (count != 0) && doneBits[headIdx];
    assign commitSeq   = seqMem[headIdx];
    assign commitTag   = tagMem[headIdx];
    assign flushReq    = commitValid && mispredMem[headIdx];   // Squash all younger

    // ------------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            headIdx  <= '0;
            tailIdx  <= '0;
            count    <= '0;
            doneBits <= '0;
        end else begin
            if (allocValid) begin
                tailIdx           <= tailIdx + 1'b1;
                doneBits[tailIdx] <= `FALSE;
            end
            // Completions land on occupied slots, never on tailIdx
            if (aluDoneValid) doneBits[aluDoneIdx] <= `TRUE;
            if (lsuDoneValid) doneBits[lsuDoneIdx] <= `TRUE;
            if (mduDoneValid) doneBits[mduDoneIdx] <= `TRUE;
            if (commitValid) begin
                headIdx <= headIdx + 1'b1;
            end
            if (allocValid && !commitValid) begin
                count <= count + 1'b1;
            end else if (commitValid && !allocValid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            seqMem[tailIdx]     <= allocInst.info.seq;
            tagMem[tailIdx]     <= allocInst.tag;
            mispredMem[tailIdx] <= allocInst.info.mispredict;
        end
    end

endmodule

// File: verilog/BackendTop.sv
`timescale 1ns/1ns

module BackendTop import BackendPkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     inValid,
    input  SeqId     inSeq,
    input  InstClass inClass,
    input  logic     inMispredict,
    output logic     inReady,

    input  logic     aluGrant,
    input  logic     lsuGrant,
    input  logic     mduGrant,
    output logic     aluIssueValid,
    output SeqId     aluIssueSeq,
    output logic     lsuIssueValid,
    output SeqId     lsuIssueSeq,
    output logic     mduIssueValid,
    output SeqId     mduIssueSeq,

    output logic     commitValid,
    output SeqId     commitSeq,
    output PhysTag   commitTag,
    output logic     flush
);

    logic       decodePause, renameRegPause, pauseRename, dispatchPause;
    logic       pipeFlush, renameRecover, robFlush, flushReq, robPauseReq;
    logic       aluIQFlush, lsuIQFlush, mduIQFlush;
    logic       aluIQReady, lsuIQReady, mduIQReady;
    logic       renameAllocatable;
    PhysTag     allocTag;

    InstInfo    frontInst, decodeData, renameData;
    RenamedInst renamedInst, dispatchData;
    logic       decodeValid, renameValid, dispatchValid, dispatchFire;
    RobIdx      robAllocIdx;
    IssueEntry  queueEntry, aluHead, lsuHead, mduHead;

    assign inReady   = !decodePause;
    assign frontInst = '{seq: inSeq, cls: inClass, mispredict: inMispredict};

    // ------------------------------------------------------------------------
    // Decode, rename, dispatch registers
    // ------------------------------------------------------------------------

    CtrlUnitBackend ctrlUnit (
        .robPauseReq(robPauseReq), .flushReq(flushReq), .aluIQReady(aluIQReady),
        .lsuIQReady(lsuIQReady), .mduIQReady(mduIQReady),
        .renameAllocatable(renameAllocatable), .decodePause(decodePause),
        .renameRegPause(renameRegPause), .pauseRename(pauseRename),
        .dispatchPause(dispatchPause), .pipeFlush(pipeFlush),
        .renameRecover(renameRecover), .aluIQFlush(aluIQFlush), .lsuIQFlush(lsuIQFlush),
        .mduIQFlush(mduIQFlush), .robFlush(robFlush), .flush(flush)
    );

    PipeReg #(.PayloadType(InstInfo)) decodeReg (
        .clk(clk), .reset(reset), .pause(decodePause), .flush(pipeFlush),
        .inValid(inValid), .inData(frontInst), .outValid(decodeValid), .outData(decodeData)
    );

    PipeReg #(.PayloadType(InstInfo)) renameReg (
        .clk(clk), .reset(reset), .pause(renameRegPause), .flush(pipeFlush),
        .inValid(decodeValid), .inData(decodeData),
        .outValid(renameValid), .outData(renameData)
    );

    RenameUnit renameUnit (
        .clk(clk), .reset(reset), .allocReq(renameValid), .pauseRename(pauseRename),
        .freeValid(commitValid), .freeTag(commitTag), .recover(renameRecover),
        .allocatable(renameAllocatable), .allocTag(allocTag)
    );

    assign renamedInst = '{info: renameData, tag: allocTag};

    // No tag means a bubble moves on while the rename register holds
    PipeReg #(.PayloadType(RenamedInst)) dispatchReg (
        .clk(clk), .reset(reset), .pause(dispatchPause), .flush(pipeFlush),
        .inValid(renameValid && renameAllocatable), .inData(renamedInst),
        .outValid(dispatchValid), .outData(dispatchData)
    );

    // ------------------------------------------------------------------------
    // Issue queues and reorder buffer
    // ------------------------------------------------------------------------

    assign dispatchFire = dispatchValid && !dispatchPause;
    assign queueEntry   = '{seq: dispatchData.info.seq, robIdx: robAllocIdx};

    IssueQueue aluQueue (
        .clk(clk), .reset(reset), .flush(aluIQFlush),
        .writeValid(dispatchFire && dispatchData.info.cls == ClassAlu),
        .writeEntry(queueEntry), .grant(aluGrant), .ready(aluIQReady),
        .issueValid(aluIssueValid), .issueEntry(aluHead)
    );

    IssueQueue lsuQueue (
        .clk(clk), .reset(reset), .flush(lsuIQFlush),
        .writeValid(dispatchFire && dispatchData.info.cls == ClassLsu),
        .writeEntry(queueEntry), .grant(lsuGrant), .ready(lsuIQReady),
        .issueValid(lsuIssueValid), .issueEntry(lsuHead)
    );

    IssueQueue mduQueue (
        .clk(clk), .reset(reset), .flush(mduIQFlush),
        .writeValid(dispatchFire && dispatchData.info.cls == ClassMdu),
        .writeEntry(queueEntry), .grant(mduGrant), .ready(mduIQReady),
        .issueValid(mduIssueValid), .issueEntry(mduHead)
    );

    assign aluIssueSeq = aluHead.seq;
    assign lsuIssueSeq = lsuHead.seq;
    assign mduIssueSeq = mduHead.seq;

    // Issue counts as completion
    ReorderBuffer rob (
        .clk(clk), .reset(reset), .flush(robFlush), .allocValid(dispatchFire),
        .allocInst(dispatchData), .allocIdx(robAllocIdx), .pauseReq(robPauseReq),
        .aluDoneValid(aluGrant && aluIssueValid), .aluDoneIdx(aluHead.robIdx),
        .lsuDoneValid(lsuGrant && lsuIssueValid), .lsuDoneIdx(lsuHead.robIdx),
        .mduDoneValid(mduGrant && mduIssueValid), .mduDoneIdx(mduHead.robIdx),
        .commitValid(commitValid), .commitSeq(commitSeq), .commitTag(commitTag),
        .flushReq(flushReq)
    );

endmodule

// File: bench/BackendTb_asserts.sv
`timescale 1ns/1ns

module BackendTb_asserts import BackendPkg::*; (
    input logic clk,
    input logic reset,
    input logic inReady,
    input logic commitValid,
    input logic flush,
    input logic aluIssueValid,
    input logic lsuIssueValid,
    input logic mduIssueValid,
    input logic aluGrant,
    input logic lsuGrant,
    input logic mduGrant,
    input SeqId aluIssueSeq,
    input SeqId lsuIssueSeq,
    input SeqId mduIssueSeq
);

    int failCount = 0;      // Polled by the testbench every cycle

    // ------------------------------------------------------------------------
    // Reset and flush
    // ------------------------------------------------------------------------

    resetIdle: assert property (@(posedge clk) reset |=> inReady && !commitValid && !flush)
        else begin
            failCount++;
            $error("Backend is not empty and open right after reset");
        end

    // One edge clears every stage, queue and buffer entry
    flushEmpties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !commitValid && !aluIssueValid && !lsuIssueValid && !mduIssueValid && inReady)
        else begin
            failCount++;
            $error("Backend still holds work one cycle after a flush");
        end

    // ------------------------------------------------------------------------
    // Issue heads stay put until granted
    // ------------------------------------------------------------------------

    aluHeadHeld: assert property (@(posedge clk) disable iff (reset)
        aluIssueValid && !aluGrant && !flush |=> aluIssueValid && $stable(aluIssueSeq))
        else begin
            failCount++;
            $error("ALU queue head changed without a grant");
        end

    lsuHeadHeld: assert property (@(posedge clk) disable iff (reset)
        lsuIssueValid && !lsuGrant && !flush |=> lsuIssueValid && $stable(lsuIssueSeq))
        else begin
            failCount++;
            $error("LSU queue head changed without a grant");
        end

    mduHeadHeld: assert property (@(posedge clk) disable iff (reset)
        mduIssueValid && !mduGrant && !flush |=> mduIssueValid && $stable(mduIssueSeq))
        else begin
            failCount++;
            $error("MDU queue head changed without a grant");
        end

endmodule

// File: bench/BackendTb.sv
`timescale 1ns/1ns
`include "backend_defines.svh"

module BackendTb import BackendPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int numInsts  = 400;
    localparam int liveBound = `PHYS_TAGS + 3 + 3 * `IQ_DEPTH;   // Tags plus stage regs and queues

    typedef struct {
        int       seq;
        InstClass cls;
        bit       mispredict;
    } SentInst;

    logic     clk, reset, inValid, inMispredict, inReady, flush, commitValid;
    logic     aluGrant, lsuGrant, mduGrant, aluIssueValid, lsuIssueValid, mduIssueValid;
    SeqId     inSeq, aluIssueSeq, lsuIssueSeq, mduIssueSeq, commitSeq;
    InstClass inClass;
    PhysTag   commitTag;

    SentInst  pending[$];       // Accepted, not yet committed or squashed
    PhysTag   recentTags[$];    // Commit tags since the last flush
    int       lastPopped[3];
    int       seed = 71614;
    int       accepted = 0;
    int       cycle = 0;
    bit       sawStall = 1'b0;

    BackendTop dut_i (.*);

    bind BackendTop BackendTb_asserts assertsInst (
        .clk(clk), .reset(reset), .inReady(inReady), .commitValid(commitValid),
        .flush(flush), .aluIssueValid(aluIssueValid), .lsuIssueValid(lsuIssueValid),
        .mduIssueValid(mduIssueValid), .aluGrant(aluGrant), .lsuGrant(lsuGrant),
        .mduGrant(mduGrant), .aluIssueSeq(aluIssueSeq), .lsuIssueSeq(lsuIssueSeq),
        .mduIssueSeq(mduIssueSeq)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(clkPeriod * (numInsts * 20 + 200));
        stopWithFailure("Watchdog expired before the backend drained");
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compareValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stopWithFailure($sformatf("** Error at %0t ns: %s expected %0d, actual %0d",
                                      $time, name, expected, actual));
        end
    endtask

    function automatic int findPending(input int seq);
        foreach (pending[i]) begin
            if (pending[i].seq == seq) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic bit tagInWindow(input PhysTag tag);
        foreach (recentTags[i]) begin
            if (recentTags[i] == tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic checkIssue(input InstClass cls, input logic valid, input SeqId seq,
                              input logic grant);
        int idx;
        idx = findPending(int'(seq));
        if (valid) begin
            if (idx < 0 || pending[idx].cls != cls) begin
                stopWithFailure($sformatf("Seq %0d shown on the %s queue is not outstanding there",
                                          seq, cls.name()));
            end
            if (int'(seq) <= lastPopped[cls]) begin
                stopWithFailure($sformatf("Seq %0d issued out of order on the %s queue",
                                          seq, cls.name()));
            end
            if (grant) begin
                lastPopped[cls] = int'(seq);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // One clock: drive at the falling edge, predict the next rising edge
    // ------------------------------------------------------------------------

    task automatic runCycle(input bit sending, input bit holdMdu);
        SentInst sent;
        @(negedge clk);
        if (dut_i.assertsInst.failCount != 0) begin
            stopWithFailure("A bound assertion failed");
        end
        inValid      = sending && ({$random(seed)} % 10 < 7);
        inSeq        = SeqId'(accepted);
        inClass      = InstClass'({$random(seed)} % 3);
        inMispredict = ({$random(seed)} % 20 == 0);
        aluGrant     = !sending || 1'($random(seed));   // Drain grants everything
        lsuGrant     = !sending || 1'($random(seed));
        mduGrant     = !holdMdu && (!sending || 1'($random(seed)));
        if (!inReady) begin
            sawStall = 1'b1;
        end
        checkIssue(ClassAlu, aluIssueValid, aluIssueSeq, aluGrant);
        checkIssue(ClassLsu, lsuIssueValid, lsuIssueSeq, lsuGrant);
        checkIssue(ClassMdu, mduIssueValid, mduIssueSeq, mduGrant);
        if (commitValid) begin
            if (pending.size() == 0) begin
                stopWithFailure("Commit seen with no outstanding instruction");
            end
            compareValue("commitSeq", pending[0].seq, int'(commitSeq));
            compareValue("flush", int'(pending[0].mispredict), int'(flush));
            if (tagInWindow(commitTag)) begin
                stopWithFailure($sformatf("Tag %0d committed again before reallocation",
                                          commitTag));
            end
            recentTags.push_back(commitTag);
            if (recentTags.size() > `PHYS_TAGS - 1) begin
                recentTags.pop_front();
            end
            void'(pending.pop_front());
        end else begin
            compareValue("flush", 0, int'(flush));
        end
        if (flush) begin
            pending.delete();       // Squashes the accept at this edge too
            recentTags.delete();
        end else if (inValid && inReady) begin
            sent.seq        = accepted;
            sent.cls        = inClass;
            sent.mispredict = inMispredict;
            pending.push_back(sent);
        end
        if (inValid && inReady) begin
            accepted++;
        end
        if (pending.size() > liveBound) begin
            stopWithFailure($sformatf("%0d instructions in flight, more than %0d",
                                      pending.size(), liveBound));
        end
    endtask

    initial begin
        reset        = 1'b1;
        inValid      = 1'b0;
        inSeq        = '0;
        inClass      = ClassAlu;
        inMispredict = 1'b0;
        aluGrant     = 1'b0;
        lsuGrant     = 1'b0;
        mduGrant     = 1'b0;
        lastPopped   = '{-1, -1, -1};
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (accepted < numInsts) begin
            if (cycle % 200 == 120) begin
                sawStall = 1'b0;
            end
            runCycle(1'b1, (cycle % 200) >= 120);   // MDU starved in the late phase
            cycle++;
            if (cycle % 200 == 0 && !sawStall) begin
                stopWithFailure("inReady never dropped while MDU grants were held low");
            end
        end
        while (pending.size() != 0) begin
            runCycle(1'b0, 1'b0);
        end
        repeat (4) runCycle(1'b0, 1'b0);
        if (dut_i.assertsInst.failCount == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stopWithFailure("A bound assertion failed");
        end
    end

endmodule

// File: sources.f
+incdir+common
common/BackendPkg.sv
verilog/CtrlUnitBackend.sv
verilog/PipeReg.sv
rename/RenameUnit.sv
issue/IssueQueue.sv
rob/ReorderBuffer.sv
verilog/BackendTop.sv
bench/BackendTb_asserts.sv
bench/BackendTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = BackendTb
FILELIST = sources.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	-./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
